//--- Bender.yml
package:
  name: saturn_pad

sources:
  - include_dirs:
      - .
    files:
      - pad_pkg.sv
      - analog_pad_seq.sv
      - pad_port.sv
      - saturn_pad_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_saturn_pad.sv

//--- analog_pad_seq.sv
`include "pad_defs.svh"

module analog_pad_seq
	import pad_pkg::*;
(
	input  logic                  CLK,
	input  logic                  RST_N,
	input  logic                  smpc_ce_i,
	input  pad_type_e             pad_type_i,
	input  logic                  th_i,
	input  logic                  tr_i,
	input  logic [`PAD_BTN_W-1:0] buttons_i,
	input  axes_t                 axes_i,
	output logic                  tl_o,
	output logic [`PAD_NIB_W-1:0] nibble_o
);

	logic [`PAD_STATE_W-1:0] step_q;
	logic [`PAD_STATE_W-1:0] step_nxt;
	logic [`PAD_STATE_W-1:0] last_step;
	logic [`PAD_NIB_W-1:0]   nib_q;
	logic [`PAD_NIB_W-1:0]   nib_nxt;
	logic [`PAD_NIB_W-1:0]   type_id;
	logic                    tl_q;
	logic                    is_analog;
	logic                    idle_cmd;
	logic                    want_tr;
	logic                    level_ok;

	function automatic logic [`PAD_NIB_W-1:0] axis_hi(input logic [`PAD_AXIS_W-1:0] a);
		return a[`PAD_AXIS_W-1:`PAD_NIB_W] ^ `PAD_AXIS_FLIP;
	endfunction

	function automatic logic [`PAD_NIB_W-1:0] axis_lo(input logic [`PAD_AXIS_W-1:0] a);
		return a[`PAD_NIB_W-1:0];
	endfunction

	// Packet identity and length per type
	always_comb begin
		is_analog = 1'b1;
		type_id   = `PAD_ID_MISSION;
		last_step = `PAD_STATE_W'(14);
		case (pad_type_i)
			WHEEL: begin
				type_id   = `PAD_ID_WHEEL;
				last_step = `PAD_STATE_W'(10);
			end
			MISSION: begin
				type_id   = `PAD_ID_MISSION;
				last_step = `PAD_STATE_W'(14);
			end
			PAD_3D: begin
				type_id   = `PAD_ID_3D;
				last_step = `PAD_STATE_W'(16);
			end
			DUALMISSION: begin
				type_id   = `PAD_ID_DUAL;
				last_step = `PAD_STATE_W'(22);
			end
			default: begin
				is_analog = 1'b0;
			end
		endcase
	end

	// Steps 0 and 1 both wait for the first TR pulse, odd steps want TR high
	assign idle_cmd = th_i & tr_i;
	assign want_tr  = (step_q < `PAD_STATE_W'(2)) | step_q[0];
	assign level_ok = ~th_i & (tr_i == want_tr);
	assign step_nxt = (step_q == '0) ? `PAD_STATE_W'(2) : step_q + 1'b1;

	// Nibble presented once the sequencer reaches step_nxt
	always_comb begin
		case (step_nxt)
			2, 3: nib_nxt = 4'h1;
			4: nib_nxt = type_id;
			5: nib_nxt = buttons_i[15:12];
			6: nib_nxt = buttons_i[11:8];
			7: begin
				if (pad_type_i == WHEEL)
					nib_nxt = {1'b1, buttons_i[6:4]};
				else
					nib_nxt = buttons_i[7:4];
			end
			8: begin
				if (pad_type_i == WHEEL)
					nib_nxt = 4'hF;
				else
					nib_nxt = buttons_i[3:0];
			end
			9: nib_nxt = axis_hi(axes_i.x1);
			10: nib_nxt = axis_lo(axes_i.x1);
			11: nib_nxt = axis_hi(axes_i.y1);
			12: nib_nxt = axis_lo(axes_i.y1);
			// The 3D pad closes with 0 then 1, dual mission opens its second stick with F F
			15: nib_nxt = (pad_type_i == DUALMISSION) ? 4'hF : 4'h0;
			16: nib_nxt = (pad_type_i == DUALMISSION) ? 4'hF : 4'h1;
			17: nib_nxt = axis_hi(axes_i.x2);
			18: nib_nxt = axis_lo(axes_i.x2);
			19: nib_nxt = axis_hi(axes_i.y2);
			20: nib_nxt = axis_lo(axes_i.y2);
			default: nib_nxt = 4'h0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			step_q <= '0;
			nib_q  <= '0;
			tl_q   <= 1'b1;
		end else if (smpc_ce_i && is_analog) begin
			if (idle_cmd) begin
				step_q <= '0;
				nib_q  <= `PAD_NIB_W'(1);
				tl_q   <= 1'b1;
			end else if (level_ok && step_q < last_step) begin
				step_q <= step_nxt;
				nib_q  <= nib_nxt;
				// TL is low on odd steps and high on even ones
				tl_q   <= ~step_nxt[0];
			end
		end
	end

	assign tl_o     = tl_q;
	assign nibble_o = nib_q;

endmodule

//--- build.f
+incdir+.
pad_pkg.sv
analog_pad_seq.sv
pad_port.sv
saturn_pad_top.sv
tb_saturn_pad.sv

//--- pad_defs.svh
`ifndef PAD_DEFS_SVH
`define PAD_DEFS_SVH

// Port pin and field widths
`define PAD_PIN_W    7
`define PAD_NIB_W    4
`define PAD_BTN_W    16
`define PAD_AXIS_W   8
`define PAD_STATE_W  5
`define PAD_TYPE_W   4

// Flips the sign bit of an axis high nibble so the console sees an unsigned value
`define PAD_AXIS_FLIP 4'h8

// Type nibbles sent in the third slot of an analog packet
`define PAD_ID_WHEEL   4'h3
`define PAD_ID_MISSION 4'h5
`define PAD_ID_3D      4'h6
`define PAD_ID_DUAL    4'h9

`endif

//--- pad_pkg.sv
`include "pad_defs.svh"

package pad_pkg;

	// Codes 6 and 7 are left unnamed and read as the pulled-up word
	typedef enum logic [`PAD_TYPE_W-1:0] {
		DIGITAL     = 4'd0,
		VIRT_LGUN   = 4'd1,
		WHEEL       = 4'd2,
		MISSION     = 4'd3,
		PAD_3D      = 4'd4,
		DUALMISSION = 4'd5,
		OFF         = 4'd8
	} pad_type_e;

	typedef struct packed {
		logic [`PAD_PIN_W-1:0] pdr_o;
		logic [`PAD_PIN_W-1:0] ddr;
	} port_bus_t;

	typedef struct packed {
		logic [`PAD_AXIS_W-1:0] x1;
		logic [`PAD_AXIS_W-1:0] y1;
		logic [`PAD_AXIS_W-1:0] x2;
		logic [`PAD_AXIS_W-1:0] y2;
	} axes_t;

	typedef struct packed {
		logic trig;
		logic start;
		logic sensor;
	} lgun_t;

	// Buttons are active low, gun inputs active high
	typedef struct packed {
		pad_type_e             pad_type;
		logic [`PAD_BTN_W-1:0] buttons;
		axes_t                 axes;
		lgun_t                 lgun;
	} pad_in_t;

	typedef struct packed {
		logic                  th;
		logic                  tr;
		logic                  tl;
		logic [`PAD_NIB_W-1:0] data;
	} pin_std_t;

	typedef struct packed {
		logic                  latch_n;
		logic                  start_n;
		logic                  trig_n;
		logic [`PAD_NIB_W-1:0] id;
	} pin_gun_t;

	typedef union packed {
		pin_std_t std;
		pin_gun_t gun;
	} pad_pin_u;

endpackage

//--- pad_port.sv
`include "pad_defs.svh"

module pad_port
	import pad_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      smpc_ce_i,
	input  port_bus_t bus_i,
	input  pad_in_t   pad_i,
	output pad_pin_u  pdr_i_o
);

	localparam logic [`PAD_NIB_W-1:0] gun_id = 4'b1100;

	pad_pin_u              cmd;
	logic [`PAD_PIN_W-1:0] base_word;
	logic [`PAD_NIB_W-1:0] dig_nibble;
	logic [`PAD_NIB_W-1:0] th_high_nibble;
	logic                  dig_valid;
	logic [`PAD_NIB_W-1:0] seq_nibble;
	logic                  seq_tl;

	assign cmd = bus_i.pdr_o;

	// Driven pins read back their own level, undriven pins are pulled up
	assign base_word = (bus_i.pdr_o & bus_i.ddr) | ~bus_i.ddr;

	assign th_high_nibble = {pad_i.buttons[3], 3'b100};

	analog_pad_seq u_seq (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.smpc_ce_i  (smpc_ce_i),
		.pad_type_i (pad_i.pad_type),
		.th_i       (cmd.std.th),
		.tr_i       (cmd.std.tr),
		.buttons_i  (pad_i.buttons),
		.axes_i     (pad_i.axes),
		.tl_o       (seq_tl),
		.nibble_o   (seq_nibble)
	);

	// Digital pad nibble select, TH-only or TH/TR mode by ddr
	always_comb begin
		dig_valid  = 1'b1;
		dig_nibble = th_high_nibble;
		case (bus_i.ddr[6:5])
			2'b10: begin
				if (!cmd.std.th)
					dig_nibble = pad_i.buttons[15:12];
			end
			2'b11: begin
				case ({cmd.std.th, cmd.std.tr})
					2'b00: dig_nibble = pad_i.buttons[7:4];
					2'b01: dig_nibble = pad_i.buttons[15:12];
					2'b10: dig_nibble = pad_i.buttons[11:8];
					default: dig_nibble = th_high_nibble;
				endcase
			end
			default: begin
				dig_valid = 1'b0;
			end
		endcase
	end

	always_comb begin
		pdr_i_o = base_word;
		case (pad_i.pad_type)
			DIGITAL: begin
				if (dig_valid)
					pdr_i_o.std.data = dig_nibble;
			end
			// The gun owns every pin, whatever the console drives
			VIRT_LGUN: begin
				pdr_i_o.gun.latch_n = ~pad_i.lgun.sensor;
				pdr_i_o.gun.start_n = ~pad_i.lgun.start;
				pdr_i_o.gun.trig_n  = ~pad_i.lgun.trig;
				pdr_i_o.gun.id      = gun_id;
			end
			WHEEL, MISSION, PAD_3D, DUALMISSION: begin
				pdr_i_o.std.tl   = seq_tl;
				pdr_i_o.std.data = seq_nibble;
			end
			default: begin
				pdr_i_o = base_word;
			end
		endcase
	end

endmodule

//--- saturn_pad_top.sv
`include "pad_defs.svh"

module saturn_pad_top
	import pad_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_N,
	input  logic      smpc_ce_i,

	input  port_bus_t bus1_i,
	input  port_bus_t bus2_i,

	input  pad_in_t   pad1_i,
	input  pad_in_t   pad2_i,

	output pad_pin_u  pdr1_i_o,
	output pad_pin_u  pdr2_i_o
);

	// Both ports share the CE strobe but keep separate sequencer state
	pad_port u_port1 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce_i (smpc_ce_i),
		.bus_i     (bus1_i),
		.pad_i     (pad1_i),
		.pdr_i_o   (pdr1_i_o)
	);

	pad_port u_port2 (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce_i (smpc_ce_i),
		.bus_i     (bus2_i),
		.pad_i     (pad2_i),
		.pdr_i_o   (pdr2_i_o)
	);

endmodule

//--- tb_saturn_pad.sv
`include "pad_defs.svh"

module tb_saturn_pad
	import pad_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// 300 packets of up to 23 steps at up to 20 cycles each, plus the static tests
	localparam int MAX_CYCLES = 200000;

	logic      CLK;
	logic      RST_N;
	logic      smpc_ce;
	port_bus_t bus [0:1];
	pad_in_t   pad [0:1];
	pad_pin_u  pdr1;
	pad_pin_u  pdr2;
	integer    seed = 32'h53ec;
	integer    ce_seed = 32'h53ec;
	int        cycle_cnt;
	int        ce_cnt;

	// Reference model of the analog packet protocol, one entry per port
	logic [`PAD_NIB_W-1:0] pkt_mem [0:1][0:22];
	int                    pkt_len [0:1];
	int                    m_cnt   [0:1];
	logic [`PAD_NIB_W-1:0] m_nib   [0:1];
	logic                  m_tl    [0:1];

	saturn_pad_top u_saturn_pad_top (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce_i (smpc_ce),
		.bus1_i    (bus[0]),
		.bus2_i    (bus[1]),
		.pad1_i    (pad[0]),
		.pad2_i    (pad[1]),
		.pdr1_i_o  (pdr1),
		.pdr2_i_o  (pdr2)
	);

	always #4 CLK = ~CLK;

	// Roughly one CE strobe in three cycles
	always @(posedge CLK) begin
		smpc_ce <= ({$random(ce_seed)} % 3) == 0;
		if (smpc_ce)
			ce_cnt <= ce_cnt + 1;
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles without reaching the end of the tests",
				MAX_CYCLES);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	function automatic pad_pin_u read_pdr(input int p);
		return (p == 0) ? pdr1 : pdr2;
	endfunction

	function automatic logic [6:0] base_word(input port_bus_t b);
		logic [6:0] w;
		for (int i = 0; i < 7; i++)
			w[i] = b.ddr[i] ? b.pdr_o[i] : 1'b1;
		return w;
	endfunction

	function automatic logic [6:0] dig_expect(input port_bus_t b, input logic [15:0] btn);
		logic [6:0] w;
		logic       th;
		logic       tr;
		w  = base_word(b);
		th = b.pdr_o[6];
		tr = b.pdr_o[5];
		if (b.ddr[6:5] == 2'b10) begin
			w[3:0] = th ? {btn[3], 3'b100} : btn[15:12];
		end else if (b.ddr[6:5] == 2'b11) begin
			if (th && tr)
				w[3:0] = {btn[3], 3'b100};
			else if (th)
				w[3:0] = btn[11:8];
			else if (tr)
				w[3:0] = btn[15:12];
			else
				w[3:0] = btn[7:4];
		end
		return w;
	endfunction

	function automatic logic [6:0] seq_expect(input int p);
		logic [6:0] w;
		w      = base_word(bus[p]);
		w[4]   = m_tl[p];
		w[3:0] = m_nib[p];
		return w;
	endfunction

	function automatic logic [3:0] axis_hi(input logic [7:0] a);
		return a[7:4] ^ 4'h8;
	endfunction

	task automatic check_value(input string name, input logic [6:0] exp, input logic [6:0] act);
		assert (act === exp) else begin
			$display("MISMATCH %s: expected %h actual %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic set_pad(input int p, input pad_type_e t);
		pad_in_t     v;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		r1         = $random(seed);
		r2         = $random(seed);
		r3         = $random(seed);
		v.pad_type = t;
		v.buttons  = r1[15:0];
		v.axes     = r2;
		v.lgun     = r3[2:0];
		pad[p] <= v;
	endtask

	task automatic set_bus(input int p, input logic [31:0] pdr_w, input logic [31:0] ddr_w);
		bus[p] <= {pdr_w[6:0], ddr_w[6:0]};
	endtask

	// TH and TR driven at bits 6:5, the lower pins random
	task automatic set_pins(input int p, input logic th, input logic tr, input logic [1:0] ddr_hi);
		logic [31:0] r;
		r = $random(seed);
		bus[p] <= {th, tr, r[4:0], ddr_hi, r[12:8]};
	endtask

	task automatic push_nib(input int p, input logic [3:0] v);
		pkt_mem[p][pkt_len[p]] = v;
		pkt_len[p] = pkt_len[p] + 1;
	endtask

	task automatic build_packet(input int p);
		pad_in_t v;
		v = pad[p];
		pkt_len[p] = 0;
		push_nib(p, 4'h1);
		push_nib(p, 4'h1);
		if (v.pad_type == WHEEL) begin
			push_nib(p, 4'h3);
			push_nib(p, v.buttons[15:12]);
			push_nib(p, v.buttons[11:8]);
			push_nib(p, {1'b1, v.buttons[6:4]});
			push_nib(p, 4'hF);
			push_nib(p, axis_hi(v.axes.x1));
			push_nib(p, v.axes.x1[3:0]);
		end else begin
			case (v.pad_type)
				MISSION: push_nib(p, 4'h5);
				PAD_3D: push_nib(p, 4'h6);
				default: push_nib(p, 4'h9);
			endcase
			for (int i = 3; i >= 0; i--)
				push_nib(p, v.buttons[i*4 +: 4]);
			push_nib(p, axis_hi(v.axes.x1));
			push_nib(p, v.axes.x1[3:0]);
			push_nib(p, axis_hi(v.axes.y1));
			push_nib(p, v.axes.y1[3:0]);
			push_nib(p, 4'h0);
			push_nib(p, 4'h0);
			if (v.pad_type == PAD_3D) begin
				push_nib(p, 4'h0);
				push_nib(p, 4'h1);
			end
			if (v.pad_type == DUALMISSION) begin
				push_nib(p, 4'hF);
				push_nib(p, 4'hF);
				push_nib(p, axis_hi(v.axes.x2));
				push_nib(p, v.axes.x2[3:0]);
				push_nib(p, axis_hi(v.axes.y2));
				push_nib(p, v.axes.y2[3:0]);
				push_nib(p, 4'h0);
				push_nib(p, 4'h0);
			end
		end
	endtask

	// A held level is harmless, so the model may be applied repeatedly
	task automatic apply_model(input int p);
		logic th;
		logic tr;
		th = bus[p].pdr_o[6];
		tr = bus[p].pdr_o[5];
		if (th && tr) begin
			m_cnt[p] = 0;
			m_nib[p] = 4'h1;
			m_tl[p]  = 1'b1;
		end else if (!th && tr == ((m_cnt[p] % 2) == 0) && m_cnt[p] < pkt_len[p]) begin
			m_nib[p] = pkt_mem[p][m_cnt[p]];
			m_tl[p]  = (m_cnt[p] % 2) == 0;
			m_cnt[p] = m_cnt[p] + 1;
		end
	endtask

	// Returns once two CE strobes have seen the levels driven on the last edge
	task automatic settle();
		int start;
		@(negedge CLK);
		start = ce_cnt;
		while (ce_cnt < start + 2)
			@(negedge CLK);
	endtask

	task automatic step_level(input int p, input logic th, input logic tr, input string name);
		@(posedge CLK);
		set_pins(p, th, tr, 2'b11);
		settle();
		apply_model(p);
		check_value(name, seq_expect(p), read_pdr(p));
	endtask

	task automatic start_packet(input int p, input pad_type_e t, input string name);
		@(posedge CLK);
		set_pad(p, t);
		set_pins(p, 1'b1, 1'b1, 2'b11);
		settle();
		build_packet(p);
		apply_model(p);
		check_value(name, seq_expect(p), read_pdr(p));
	endtask

	task automatic send_steps(input int p, input int n, input string name);
		for (int k = 0; k < n; k++)
			step_level(p, 1'b0, (k % 2) == 0, name);
	endtask

	initial begin
		int          k0;
		int          k1;
		int          r;
		logic [31:0] rv;
		CLK       = 1'b0;
		RST_N     = 1'b0;
		smpc_ce   = 1'b0;
		cycle_cnt = 0;
		ce_cnt    = 0;
		bus[0]    = '0;
		bus[1]    = '0;
		pad[0]    = '0;
		pad[1]    = '0;
		pad[0].pad_type = MISSION;
		pad[1].pad_type = DUALMISSION;
		for (int p = 0; p < 2; p++) begin
			pkt_len[p] = 0;
			m_cnt[p]   = 0;
			m_nib[p]   = 4'h0;
			m_tl[p]    = 1'b1;
		end
		repeat (16) @(posedge CLK);
		RST_N <= 1'b1;

		// TH=0 TR=0 at step 0 is ignored, so the reset state stays visible
		repeat (4) begin
			@(negedge CLK);
			check_value("reset_state", {2'b11, 1'b1, 4'h0}, pdr1);
			check_value("reset_state", {2'b11, 1'b1, 4'h0}, pdr2);
		end

		for (int i = 0; i < 30; i++) begin
			@(posedge CLK);
			for (int p = 0; p < 2; p++) begin
				r = {$random(seed)} % 3;
				set_pad(p, (r == 0) ? OFF : pad_type_e'(4'd6 + r[0]));
				set_bus(p, $random(seed), $random(seed));
			end
			@(negedge CLK);
			for (int p = 0; p < 2; p++)
				check_value("pullup_word", base_word(bus[p]), read_pdr(p));
		end

		// Port 1 walks every TH/TR/mode combination, port 2 is random
		for (int i = 0; i < 64; i++) begin
			@(posedge CLK);
			rv = $random(seed);
			set_pad(0, DIGITAL);
			set_pad(1, DIGITAL);
			set_pins(0, i[0], i[1], {1'b1, i[2]});
			set_pins(1, rv[0], rv[1], {1'b1, rv[2]});
			@(negedge CLK);
			for (int p = 0; p < 2; p++)
				check_value("digital_pad", dig_expect(bus[p], pad[p].buttons), read_pdr(p));
		end

		for (int i = 0; i < 40; i++) begin
			@(posedge CLK);
			for (int p = 0; p < 2; p++) begin
				set_pad(p, VIRT_LGUN);
				set_bus(p, $random(seed), $random(seed));
			end
			@(negedge CLK);
			for (int p = 0; p < 2; p++)
				check_value("light_gun", {~pad[p].lgun.sensor, ~pad[p].lgun.start,
					~pad[p].lgun.trig, 4'b1100}, read_pdr(p));
		end

		for (int i = 0; i < 80; i++) begin
			start_packet(i % 2, (i < 40) ? MISSION : PAD_3D, "full_packet");
			send_steps(i % 2, pkt_len[i % 2] + 2, "full_packet");
		end

		for (int i = 0; i < 80; i++) begin
			start_packet(i % 2, (i < 40) ? WHEEL : DUALMISSION, "idle_insert");
			r = {$random(seed)} % pkt_len[i % 2];
			send_steps(i % 2, r, "idle_insert");
			step_level(i % 2, 1'b1, 1'b1, "idle_insert");
			check_value("idle_restart", {2'b11, 1'b1, 4'h1}, read_pdr(i % 2));
			send_steps(i % 2, pkt_len[i % 2] + 1, "idle_insert");
		end

		// Port 1 advances every time, port 2 only on random turns
		for (int i = 0; i < 60; i++) begin
			@(posedge CLK);
			set_pad(0, (i % 2) ? PAD_3D : MISSION);
			set_pad(1, (i % 2) ? WHEEL : DUALMISSION);
			set_pins(0, 1'b1, 1'b1, 2'b11);
			set_pins(1, 1'b1, 1'b1, 2'b11);
			settle();
			k0 = 0;
			k1 = 0;
			for (int p = 0; p < 2; p++) begin
				build_packet(p);
				apply_model(p);
				check_value("dual_port", seq_expect(p), read_pdr(p));
			end
			while (k0 <= pkt_len[0] || k1 <= pkt_len[1]) begin
				@(posedge CLK);
				if (k0 <= pkt_len[0]) begin
					set_pins(0, 1'b0, (k0 % 2) == 0, 2'b11);
					k0++;
				end
				if (k1 <= pkt_len[1] && ({$random(seed)} % 2) == 1) begin
					set_pins(1, 1'b0, (k1 % 2) == 0, 2'b11);
					k1++;
				end
				settle();
				for (int p = 0; p < 2; p++) begin
					apply_model(p);
					check_value("dual_port", seq_expect(p), read_pdr(p));
				end
			end
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule
